/* source/exe_cfg.svh */
`ifndef EXE_CFG_SVH
`define EXE_CFG_SVH

// data and pc width
`define EXE_XLEN 32

// destination register address width
`define EXE_RADDR_W 5

// pc increment of one instruction
`define EXE_PC_STEP 4

`endif

/* source/exe_pkg.sv */
`default_nettype none

`include "exe_cfg.svh"

package exe_pkg;

    typedef logic [`EXE_XLEN-1:0] word_t;
    typedef logic [`EXE_RADDR_W-1:0] raddr_t;

    // alu ops first, then branches and jal
    typedef enum logic [3:0] {
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_SLT,
        OP_SLTU,
        OP_SLL,
        OP_SRL,
        OP_BEQ,
        OP_BNE,
        OP_BLT,
        OP_BGE,
        OP_JAL
    } exe_op_e;

    // flush discards wrong-path ops until the target pc shows up
    typedef enum logic {
        CS_RUN,
        CS_FLUSH
    } commit_state_e;

endpackage

`default_nettype wire

/* source/exe_op_if.sv */
`timescale 1ns/1ps
`default_nettype none

`include "exe_cfg.svh"

interface exe_op_if;

    logic               valid;
    logic               ready;
    exe_pkg::word_t     pc;
    exe_pkg::exe_op_e   op;
    exe_pkg::word_t     a;
    exe_pkg::word_t     b;
    exe_pkg::word_t     imm;
    exe_pkg::word_t     pred_pc;
    exe_pkg::raddr_t    rd;

    modport src (
        output valid, pc, op, a, b, imm, pred_pc, rd,
        input  ready
    );

    modport snk (
        input  valid, pc, op, a, b, imm, pred_pc, rd,
        output ready
    );

endinterface

`default_nettype wire

/* source/exe_alu_unit.sv */
`timescale 1ns/1ps
`default_nettype none

`include "exe_cfg.svh"

module exe_alu_unit (
    input  logic            clk,
    input  logic            arst_n_i,
    exe_op_if.snk           op_if,
    output logic            alu_valid_o,
    input  logic            alu_ready_i,
    output exe_pkg::word_t  alu_data_o
);

    logic                           valid_q;
    exe_pkg::word_t                 data_q;
    exe_pkg::word_t                 res;
    logic [$clog2(`EXE_XLEN)-1:0]   shamt;

    assign shamt = op_if.b[$clog2(`EXE_XLEN)-1:0];

    always_comb begin
        res = '0;
        case (op_if.op)
            exe_pkg::OP_ADD:  res = op_if.a + op_if.b;
            exe_pkg::OP_SUB:  res = op_if.a - op_if.b;
            exe_pkg::OP_AND:  res = op_if.a & op_if.b;
            exe_pkg::OP_OR:   res = op_if.a | op_if.b;
            exe_pkg::OP_XOR:  res = op_if.a ^ op_if.b;
            exe_pkg::OP_SLT:  res = exe_pkg::word_t'($signed(op_if.a) < $signed(op_if.b));
            exe_pkg::OP_SLTU: res = exe_pkg::word_t'(op_if.a < op_if.b);
            exe_pkg::OP_SLL:  res = op_if.a << shamt;
            exe_pkg::OP_SRL:  res = op_if.a >> shamt;
            // branches and jal leave the alu result at zero
            default:          res = '0;
        endcase
    end

    // free when empty or when the held result leaves this cycle
    assign op_if.ready = !valid_q || alu_ready_i;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q <= 1'b0;
        end else if (op_if.ready) begin
            valid_q <= op_if.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (op_if.valid && op_if.ready) begin
            data_q <= res;
        end
    end

    assign alu_valid_o = valid_q;
    assign alu_data_o  = data_q;

    a_alu_hold: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        alu_valid_o && !alu_ready_i |=> alu_valid_o && $stable(alu_data_o)
    );

endmodule

`default_nettype wire

/* source/exe_branch_unit.sv */
`timescale 1ns/1ps
`default_nettype none

`include "exe_cfg.svh"

module exe_branch_unit (
    input  logic                clk,
    input  logic                arst_n_i,
    exe_op_if.snk               op_if,
    output logic                br_valid_o,
    input  logic                br_ready_i,
    output exe_pkg::word_t      br_pc_o,
    output exe_pkg::raddr_t     br_rd_o,
    output exe_pkg::exe_op_e    br_op_o,
    output exe_pkg::word_t      br_next_pc_o,
    output logic                br_mispredict_o
);

    logic               valid_q;
    logic               taken;
    exe_pkg::word_t     next_pc;
    exe_pkg::word_t     pc_q;
    exe_pkg::raddr_t    rd_q;
    exe_pkg::exe_op_e   op_q;
    exe_pkg::word_t     next_pc_q;
    logic               mispredict_q;

    always_comb begin
        case (op_if.op)
            exe_pkg::OP_BEQ: taken = op_if.a == op_if.b;
            exe_pkg::OP_BNE: taken = op_if.a != op_if.b;
            exe_pkg::OP_BLT: taken = $signed(op_if.a) < $signed(op_if.b);
            exe_pkg::OP_BGE: taken = $signed(op_if.a) >= $signed(op_if.b);
            exe_pkg::OP_JAL: taken = 1'b1;
            default:         taken = 1'b0;
        endcase
    end

    assign next_pc = taken ? op_if.pc + op_if.imm
                           : op_if.pc + exe_pkg::word_t'(`EXE_PC_STEP);

    assign op_if.ready = !valid_q || br_ready_i;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q <= 1'b0;
        end else if (op_if.ready) begin
            valid_q <= op_if.valid;
        end
    end

    // pc, rd and op travel with the result for commit
    always_ff @(posedge clk) begin
        if (op_if.valid && op_if.ready) begin
            pc_q         <= op_if.pc;
            rd_q         <= op_if.rd;
            op_q         <= op_if.op;
            next_pc_q    <= next_pc;
            mispredict_q <= next_pc != op_if.pred_pc;
        end
    end

    assign br_valid_o      = valid_q;
    assign br_pc_o         = pc_q;
    assign br_rd_o         = rd_q;
    assign br_op_o         = op_q;
    assign br_next_pc_o    = next_pc_q;
    assign br_mispredict_o = mispredict_q;

    a_br_hold: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        br_valid_o && !br_ready_i |=> br_valid_o && $stable(br_next_pc_o)
    );

endmodule

`default_nettype wire

/* source/exe_commit.sv */
`timescale 1ns/1ps
`default_nettype none

`include "exe_cfg.svh"

module exe_commit (
    input  logic                clk,
    input  logic                arst_n_i,
    input  logic                alu_valid_i,
    output logic                alu_ready_o,
    input  exe_pkg::word_t      alu_data_i,
    input  logic                br_valid_i,
    output logic                br_ready_o,
    input  exe_pkg::word_t      br_pc_i,
    input  exe_pkg::raddr_t     br_rd_i,
    input  exe_pkg::exe_op_e    br_op_i,
    input  exe_pkg::word_t      br_next_pc_i,
    input  logic                br_mispredict_i,
    output logic                out_valid_o,
    input  logic                out_ready_i,
    output exe_pkg::word_t      out_pc_o,
    output exe_pkg::raddr_t     out_rd_o,
    output exe_pkg::word_t      out_data_o,
    output logic                out_wen_o,
    output logic                redirect_valid_o,
    output exe_pkg::word_t      redirect_pc_o
);

    exe_pkg::commit_state_e state_q;
    exe_pkg::word_t         target_q;
    logic                   out_free;
    logic                   take;
    logic                   emit;
    logic                   is_branch;
    exe_pkg::word_t         wb_data;
    logic                   out_valid_q;
    logic                   out_mis_q;
    exe_pkg::word_t         out_next_pc_q;

    // both units leave together, and only when the output slot frees up
    assign out_free    = !out_valid_q || out_ready_i;
    assign take        = alu_valid_i && br_valid_i && out_free;
    assign alu_ready_o = take;
    assign br_ready_o  = take;

    // wrong-path ops are swallowed until the redirect target arrives
    assign emit = take && (state_q == exe_pkg::CS_RUN || br_pc_i == target_q);

    assign is_branch = br_op_i inside {exe_pkg::OP_BEQ, exe_pkg::OP_BNE,
                                       exe_pkg::OP_BLT, exe_pkg::OP_BGE};
    assign wb_data   = (br_op_i == exe_pkg::OP_JAL)
                     ? br_pc_i + exe_pkg::word_t'(`EXE_PC_STEP)
                     : alu_data_i;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q     <= exe_pkg::CS_RUN;
            out_valid_q <= 1'b0;
        end else begin
            if (out_free) begin
                out_valid_q <= emit;
            end
            if (emit) begin
                state_q <= br_mispredict_i ? exe_pkg::CS_FLUSH : exe_pkg::CS_RUN;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (emit) begin
            out_pc_o      <= br_pc_i;
            out_rd_o      <= br_rd_i;
            out_data_o    <= wb_data;
            out_wen_o     <= !is_branch;
            out_mis_q     <= br_mispredict_i;
            out_next_pc_q <= br_next_pc_i;
        end
        if (emit && br_mispredict_i) begin
            target_q <= br_next_pc_i;
        end
    end

    assign out_valid_o      = out_valid_q;
    assign redirect_valid_o = out_valid_q && out_mis_q;
    assign redirect_pc_o    = out_next_pc_q;

    // a shown redirect means the flush is armed on that same target
    a_redirect_with_out: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        redirect_valid_o |-> out_valid_o && state_q == exe_pkg::CS_FLUSH
                             && target_q == redirect_pc_o
    );

    // the two units are loaded and drained in lockstep
    a_units_lockstep: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        alu_valid_i == br_valid_i
    );

endmodule

`default_nettype wire

/* source/exe_core.sv */
`timescale 1ns/1ps
`default_nettype none

`include "exe_cfg.svh"

module exe_core (
    input  logic                clk,
    input  logic                arst_n_i,
    input  logic                in_valid_i,
    output logic                in_ready_o,
    input  exe_pkg::word_t      in_pc_i,
    input  exe_pkg::exe_op_e    in_op_i,
    input  exe_pkg::word_t      in_a_i,
    input  exe_pkg::word_t      in_b_i,
    input  exe_pkg::word_t      in_imm_i,
    input  exe_pkg::word_t      in_pred_pc_i,
    input  exe_pkg::raddr_t     in_rd_i,
    output logic                out_valid_o,
    input  logic                out_ready_i,
    output exe_pkg::word_t      out_pc_o,
    output exe_pkg::raddr_t     out_rd_o,
    output exe_pkg::word_t      out_data_o,
    output logic                out_wen_o,
    output logic                redirect_valid_o,
    output exe_pkg::word_t      redirect_pc_o
);

    exe_op_if alu_if ();
    exe_op_if br_if ();

    logic               alu_valid;
    logic               alu_ready;
    exe_pkg::word_t     alu_data;
    logic               br_valid;
    logic               br_ready;
    exe_pkg::word_t     br_pc;
    exe_pkg::raddr_t    br_rd;
    exe_pkg::exe_op_e   br_op;
    exe_pkg::word_t     br_next_pc;
    logic               br_mispredict;

    // same op goes to both units
    assign alu_if.valid   = in_valid_i;
    assign alu_if.pc      = in_pc_i;
    assign alu_if.op      = in_op_i;
    assign alu_if.a       = in_a_i;
    assign alu_if.b       = in_b_i;
    assign alu_if.imm     = in_imm_i;
    assign alu_if.pred_pc = in_pred_pc_i;
    assign alu_if.rd      = in_rd_i;

    assign br_if.valid    = in_valid_i;
    assign br_if.pc       = in_pc_i;
    assign br_if.op       = in_op_i;
    assign br_if.a        = in_a_i;
    assign br_if.b        = in_b_i;
    assign br_if.imm      = in_imm_i;
    assign br_if.pred_pc  = in_pred_pc_i;
    assign br_if.rd       = in_rd_i;

    // accept only when both sides can load
    assign in_ready_o = alu_if.ready && br_if.ready;

    exe_alu_unit i_alu (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .op_if       (alu_if.snk),
        .alu_valid_o (alu_valid),
        .alu_ready_i (alu_ready),
        .alu_data_o  (alu_data)
    );

    exe_branch_unit i_branch (
        .clk             (clk),
        .arst_n_i        (arst_n_i),
        .op_if           (br_if.snk),
        .br_valid_o      (br_valid),
        .br_ready_i      (br_ready),
        .br_pc_o         (br_pc),
        .br_rd_o         (br_rd),
        .br_op_o         (br_op),
        .br_next_pc_o    (br_next_pc),
        .br_mispredict_o (br_mispredict)
    );

    exe_commit i_commit (
        .clk              (clk),
        .arst_n_i         (arst_n_i),
        .alu_valid_i      (alu_valid),
        .alu_ready_o      (alu_ready),
        .alu_data_i       (alu_data),
        .br_valid_i       (br_valid),
        .br_ready_o       (br_ready),
        .br_pc_i          (br_pc),
        .br_rd_i          (br_rd),
        .br_op_i          (br_op),
        .br_next_pc_i     (br_next_pc),
        .br_mispredict_i  (br_mispredict),
        .out_valid_o      (out_valid_o),
        .out_ready_i      (out_ready_i),
        .out_pc_o         (out_pc_o),
        .out_rd_o         (out_rd_o),
        .out_data_o       (out_data_o),
        .out_wen_o        (out_wen_o),
        .redirect_valid_o (redirect_valid_o),
        .redirect_pc_o    (redirect_pc_o)
    );

endmodule

`default_nettype wire

/* tb/tb_exe_core.sv */
`timescale 1ns/1ps
`default_nettype none

`include "exe_cfg.svh"

module tb_exe_core;

    localparam int NUM_OPS    = 400;
    localparam int MAX_CYCLES = 20 * NUM_OPS + 200;

    typedef struct packed {
        exe_pkg::word_t     pc;
        exe_pkg::raddr_t    rd;
        exe_pkg::word_t     data;
        logic               wen;
        logic               mis;
        exe_pkg::word_t     next_pc;
    } exp_t;

    logic               clk;
    logic               arst_n_i;
    logic               in_valid_i;
    logic               in_ready_o;
    exe_pkg::word_t     in_pc_i;
    exe_pkg::exe_op_e   in_op_i;
    exe_pkg::word_t     in_a_i;
    exe_pkg::word_t     in_b_i;
    exe_pkg::word_t     in_imm_i;
    exe_pkg::word_t     in_pred_pc_i;
    exe_pkg::raddr_t    in_rd_i;
    logic               out_valid_o;
    logic               out_ready_i;
    exe_pkg::word_t     out_pc_o;
    exe_pkg::raddr_t    out_rd_o;
    exe_pkg::word_t     out_data_o;
    logic               out_wen_o;
    logic               redirect_valid_o;
    exe_pkg::word_t     redirect_pc_o;

    logic [31:0]        lfsr_q;
    exp_t               exp_q[$];
    int                 checks = 0;
    int                 mismatches = 0;
    int                 extra_outputs = 0;
    logic               timed_out = 1'b0;

    exe_core i_dut (.*);

    initial clk = 1'b0;
    always #5 clk = ~clk;

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // one lfsr step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            v = {v[30:0], lfsr_q[31]};
        end
        return v;
    endfunction

    function automatic exp_t ref_result(input exe_pkg::word_t pc, input exe_pkg::exe_op_e op,
                                        input exe_pkg::word_t a, input exe_pkg::word_t b,
                                        input exe_pkg::word_t imm, input exe_pkg::word_t pred,
                                        input exe_pkg::raddr_t rd);
        exp_t r;
        logic taken;
        r.pc   = pc;
        r.rd   = rd;
        r.data = '0;
        taken  = 1'b0;
        case (op)
            exe_pkg::OP_ADD:  r.data = a + b;
            exe_pkg::OP_SUB:  r.data = a - b;
            exe_pkg::OP_AND:  r.data = a & b;
            exe_pkg::OP_OR:   r.data = a | b;
            exe_pkg::OP_XOR:  r.data = a ^ b;
            exe_pkg::OP_SLT:  r.data = {31'b0, $signed(a) < $signed(b)};
            exe_pkg::OP_SLTU: r.data = {31'b0, a < b};
            exe_pkg::OP_SLL:  r.data = a << b[4:0];
            exe_pkg::OP_SRL:  r.data = a >> b[4:0];
            exe_pkg::OP_BEQ:  taken = (a == b);
            exe_pkg::OP_BNE:  taken = (a != b);
            exe_pkg::OP_BLT:  taken = ($signed(a) < $signed(b));
            exe_pkg::OP_BGE:  taken = !($signed(a) < $signed(b));
            exe_pkg::OP_JAL:  taken = 1'b1;
            default:          taken = 1'b0;
        endcase
        // link value for jal
        if (op == exe_pkg::OP_JAL) begin
            r.data = pc + `EXE_PC_STEP;
        end
        r.wen     = !(op inside {exe_pkg::OP_BEQ, exe_pkg::OP_BNE,
                                 exe_pkg::OP_BLT, exe_pkg::OP_BGE});
        r.next_pc = taken ? pc + imm : pc + `EXE_PC_STEP;
        r.mis     = (r.next_pc != pred);
        return r;
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        checks++;
        if (act !== exp) begin
            mismatches++;
            $display("[ERROR] %0t ns %s expected %h actual %h", $time, name, exp, act);
        end
    endtask

    task automatic finish_run();
        $display("checks %0d, mismatches %0d, unexpected outputs %0d, timeout %0d",
                 checks, mismatches, extra_outputs, timed_out);
        if (mismatches == 0 && extra_outputs == 0 && !timed_out) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    endtask

    initial begin : stimulus
        exp_t               cur;
        exe_pkg::exe_op_e   op;
        exe_pkg::word_t     a;
        exe_pkg::word_t     b;
        exe_pkg::word_t     imm;
        exe_pkg::word_t     pred;
        exe_pkg::raddr_t    rd;
        logic [31:0]        r;
        logic               have_op;
        logic               flushing;
        int                 wrong_left;
        int                 issued;
        int                 generated;
        exe_pkg::word_t     gen_pc;
        exe_pkg::word_t     redirect_to;
        logic               model_flush;
        exe_pkg::word_t     model_target;
        lfsr_q       = 32'hdce7;
        arst_n_i     = 1'b0;
        in_valid_i   = 1'b0;
        in_pc_i      = '0;
        in_op_i      = exe_pkg::OP_ADD;
        in_a_i       = '0;
        in_b_i       = '0;
        in_imm_i     = '0;
        in_pred_pc_i = '0;
        in_rd_i      = '0;
        out_ready_i  = 1'b0;
        have_op      = 1'b0;
        flushing     = 1'b0;
        wrong_left   = 0;
        issued       = 0;
        generated    = 0;
        gen_pc       = 32'h1000;
        redirect_to  = '0;
        model_flush  = 1'b0;
        model_target = '0;
        repeat (10) @(posedge clk);
        arst_n_i <= 1'b1;
        while (issued < NUM_OPS) begin
            @(posedge clk);
            if (in_valid_i && in_ready_o) begin
                // wrong-path ops vanish until the redirect target comes back
                if (!model_flush || cur.pc == model_target) begin
                    exp_q.push_back(cur);
                    model_flush  = cur.mis;
                    model_target = cur.next_pc;
                end
                issued++;
                have_op = 1'b0;
            end
            if (!have_op && generated < NUM_OPS) begin
                if (flushing && wrong_left == 0) begin
                    gen_pc   = redirect_to;
                    flushing = 1'b0;
                end
                op  = exe_pkg::exe_op_e'(4'(rand_bits(4) % 14));
                a   = rand_bits(32);
                b   = (rand_bits(2) == 0) ? a : rand_bits(32);
                r   = rand_bits(10);
                imm = {{20{r[9]}}, r[9:0], 2'b00};
                rd  = exe_pkg::raddr_t'(rand_bits(5));
                cur = ref_result(gen_pc, op, a, b, imm, '0, rd);
                if (flushing) begin
                    pred = gen_pc + 32'd4;
                    wrong_left--;
                end else if (rand_bits(2) == 0) begin
                    // fetch runs off the correct path for a few ops
                    pred        = cur.next_pc + 32'h100;
                    flushing    = 1'b1;
                    wrong_left  = int'(rand_bits(2));
                    redirect_to = cur.next_pc;
                end else begin
                    pred = cur.next_pc;
                end
                cur     = ref_result(gen_pc, op, a, b, imm, pred, rd);
                gen_pc  = pred;
                generated++;
                have_op = 1'b1;
            end
            if (!(in_valid_i && !in_ready_o)) begin
                in_valid_i   <= have_op && rand_bits(3) != 0;
                in_pc_i      <= cur.pc;
                in_op_i      <= op;
                in_a_i       <= a;
                in_b_i       <= b;
                in_imm_i     <= imm;
                in_pred_pc_i <= pred;
                in_rd_i      <= rd;
            end
            out_ready_i <= rand_bits(2) != 0;
        end
        while (exp_q.size() != 0) begin
            @(posedge clk);
            out_ready_i <= 1'b1;
        end
        repeat (5) @(posedge clk);
        finish_run();
    end

    always @(posedge clk) begin : compare
        exp_t e;
        if (!arst_n_i) begin
            check_value("out_valid_o", 32'd0, 32'(out_valid_o));
        end else if (out_valid_o && out_ready_i) begin
            if (exp_q.size() == 0) begin
                extra_outputs++;
                $display("output with pc %h at %0t ns was not expected", out_pc_o, $time);
            end else begin
                e = exp_q.pop_front();
                check_value("out_pc_o", e.pc, out_pc_o);
                check_value("out_rd_o", 32'(e.rd), 32'(out_rd_o));
                check_value("out_data_o", e.data, out_data_o);
                check_value("out_wen_o", 32'(e.wen), 32'(out_wen_o));
                check_value("redirect_valid_o", 32'(e.mis), 32'(redirect_valid_o));
                if (e.mis) begin
                    check_value("redirect_pc_o", e.next_pc, redirect_pc_o);
                end
            end
        end
    end

    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles < MAX_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("run stopped after %0d cycles, %0d expected results never arrived",
                 cycles, exp_q.size());
        timed_out = 1'b1;
        finish_run();
    end

endmodule

`default_nettype wire

/* all.f */
+incdir+source
source/exe_pkg.sv
source/exe_op_if.sv
source/exe_alu_unit.sv
source/exe_branch_unit.sv
source/exe_commit.sv
source/exe_core.sv
tb/tb_exe_core.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_exe_core
RTL_TOP   ?= exe_core
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "=== PASS ===" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
